//--- all.f
+incdir+include
source/noc_flit_pkg.sv
source/noc_port_pkg.sv
source/flit_ingress.sv
source/xy_route_unit.sv
source/output_switch.sv
source/mesh_router.sv
dv/tb_mesh_router.sv

//--- run_sim.sh
#!/bin/sh
# build the router testbench with Verilator, run it, and search the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_mesh_router -f all.f -o tb_mesh_router \
   > build.log 2>&1 \
   && ./obj_dir/tb_mesh_router > sim.log 2>&1 \
   || echo "build or simulation returned an error"

cat build.log sim.log 2>/dev/null | tail -n 40

grep -qx "test passed" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

//--- dv/tb_mesh_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "noc_macros.svh"

module tb_mesh_router
   import noc_flit_pkg::*;
   import noc_port_pkg::*;
();

   localparam int RST_CYCLES = 5;
   // room for the last row plus the 2-cycle latency
   localparam int MAX_CYC    = 40;
   // results other than an output port
   localparam int RES_DROP   = 5;
   localparam int RES_SEQ    = 6;

   logic                           clk = 1'b0;
   logic                           rst_n;
   port_vec_t                      in_valid;
   flit_u [`ROUTER_PORTS-1:0]      in_flit;
   wire port_vec_t                 out_valid;
   wire flit_u [`ROUTER_PORTS-1:0] out_flit;
   wire port_vec_t                 drop;
   wire port_vec_t                 seq_error;

   // stimulus table with one entry per flit
   string row_name [$];
   int    row_cyc  [$];
   int    row_port [$];
   flit_u row_flit [$];
   int    row_res  [$];

   // expected responses indexed by check cycle
   port_vec_t exp_valid [MAX_CYC];
   port_vec_t exp_drop  [MAX_CYC];
   port_vec_t exp_seq   [MAX_CYC];
   flit_u     exp_flit  [MAX_CYC][`ROUTER_PORTS];
   string     out_name  [MAX_CYC][`ROUTER_PORTS];
   string     in_name   [MAX_CYC][`ROUTER_PORTS];

   int errors        = 0;
   int cycles        = 0;
   int timeout_limit = 1000;
   int last_cyc      = 0;

   mesh_router #(
      .node_x (1),
      .node_y (2)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .out_valid (out_valid),
      .out_flit  (out_flit),
      .drop      (drop),
      .seq_error (seq_error)
   );

   always #50 clk = ~clk;

   ////////////////////
   // table helpers
   ////////////////////

   task automatic add_row(input string name, input int cyc, input int port,
                          input flit_kind_e kind, input int dest_y, input int dest_x,
                          input int res);
      flit_u f;
      f = '0;
      if (kind inside {FLIT_HEAD, FLIT_SINGLE}) begin
         f.hdr.kind   = kind;
         f.hdr.dest_y = 2'(dest_y);
         f.hdr.dest_x = 2'(dest_x);
      end else begin
         // payload flits carry random data
         f.dat.kind = kind;
         f.dat.data = 6'($urandom());
      end
      row_name.push_back(name);
      row_cyc.push_back(cyc);
      row_port.push_back(port);
      row_flit.push_back(f);
      row_res.push_back(res);
   endtask

   task automatic build_table();
      // xy routing from node (1,2) with x before y
      add_row("xy_east",  0, PORT_LOCAL, FLIT_SINGLE, 0, 3, PORT_EAST);
      add_row("xy_west",  1, PORT_LOCAL, FLIT_SINGLE, 3, 0, PORT_WEST);
      add_row("xy_north", 2, PORT_LOCAL, FLIT_SINGLE, 0, 1, PORT_NORTH);
      add_row("xy_south", 3, PORT_LOCAL, FLIT_SINGLE, 3, 1, PORT_SOUTH);
      add_row("xy_local", 4, PORT_LOCAL, FLIT_SINGLE, 2, 1, PORT_LOCAL);
      // wormhole lock on west, blocked single, reuse after tail
      add_row("worm_head",     6, PORT_EAST,  FLIT_HEAD,   1, 0, PORT_WEST);
      add_row("worm_body1",    7, PORT_EAST,  FLIT_BODY,   0, 0, PORT_WEST);
      add_row("worm_block",    7, PORT_NORTH, FLIT_SINGLE, 2, 0, RES_DROP);
      add_row("worm_body2",    8, PORT_EAST,  FLIT_BODY,   0, 0, PORT_WEST);
      add_row("worm_tail",     9, PORT_EAST,  FLIT_TAIL,   0, 0, PORT_WEST);
      add_row("worm_new_head", 10, PORT_NORTH, FLIT_HEAD,  0, 0, PORT_WEST);
      add_row("worm_new_tail", 11, PORT_NORTH, FLIT_TAIL,  0, 0, PORT_WEST);
      // two heads to east where the lower input wins
      add_row("cont_win_head",  13, PORT_WEST,  FLIT_HEAD, 2, 3, PORT_EAST);
      add_row("cont_lose_head", 13, PORT_SOUTH, FLIT_HEAD, 2, 3, RES_DROP);
      add_row("cont_win_body",  14, PORT_WEST,  FLIT_BODY, 0, 0, PORT_EAST);
      add_row("cont_lose_body", 14, PORT_SOUTH, FLIT_BODY, 0, 0, RES_DROP);
      add_row("cont_win_tail",  15, PORT_WEST,  FLIT_TAIL, 0, 0, PORT_EAST);
      add_row("cont_lose_tail", 15, PORT_SOUTH, FLIT_TAIL, 0, 0, RES_DROP);
      // order errors on the local input
      add_row("seq_lone_body", 17, PORT_LOCAL, FLIT_BODY, 0, 0, RES_SEQ);
      add_row("seq_open_head", 18, PORT_LOCAL, FLIT_HEAD, 0, 1, PORT_NORTH);
      add_row("seq_twin_head", 19, PORT_LOCAL, FLIT_HEAD, 3, 3, RES_SEQ);
      add_row("seq_close",     20, PORT_LOCAL, FLIT_TAIL, 0, 0, PORT_NORTH);
      // all five inputs at once toward five distinct outputs
      add_row("par_head_l", 22, PORT_LOCAL, FLIT_HEAD, 2, 3, PORT_EAST);
      add_row("par_head_e", 22, PORT_EAST,  FLIT_HEAD, 2, 0, PORT_WEST);
      add_row("par_head_n", 22, PORT_NORTH, FLIT_HEAD, 3, 1, PORT_SOUTH);
      add_row("par_head_w", 22, PORT_WEST,  FLIT_HEAD, 0, 1, PORT_NORTH);
      add_row("par_head_s", 22, PORT_SOUTH, FLIT_HEAD, 2, 1, PORT_LOCAL);
      add_row("par_tail_l", 23, PORT_LOCAL, FLIT_TAIL, 0, 0, PORT_EAST);
      add_row("par_tail_e", 23, PORT_EAST,  FLIT_TAIL, 0, 0, PORT_WEST);
      add_row("par_tail_n", 23, PORT_NORTH, FLIT_TAIL, 0, 0, PORT_SOUTH);
      add_row("par_tail_w", 23, PORT_WEST,  FLIT_TAIL, 0, 0, PORT_NORTH);
      add_row("par_tail_s", 23, PORT_SOUTH, FLIT_TAIL, 0, 0, PORT_LOCAL);
   endtask

   ////////////////////
   // expected values
   ////////////////////

   task automatic clear_expect();
      for (int c = 0; c < MAX_CYC; c++) begin
         exp_valid[c] = '0;
         exp_drop[c]  = '0;
         exp_seq[c]   = '0;
         for (int i = 0; i < `ROUTER_PORTS; i++) begin
            exp_flit[c][i] = '0;
            out_name[c][i] = "idle";
            in_name[c][i]  = "idle";
         end
      end
   endtask

   // seq_error one edge after sampling
   // output and drop two edges after
   task automatic expect_row(input int r);
      int c;
      int p;
      int res;
      c   = row_cyc[r];
      p   = row_port[r];
      res = row_res[r];
      if (res == RES_SEQ) begin
         exp_seq[c+1][p] = 1'b1;
         in_name[c+1][p] = row_name[r];
      end else if (res == RES_DROP) begin
         exp_drop[c+2][p] = 1'b1;
         in_name[c+2][p]  = row_name[r];
      end else begin
         exp_valid[c+2][res] = 1'b1;
         exp_flit[c+2][res]  = row_flit[r];
         out_name[c+2][res]  = row_name[r];
      end
   endtask

   ////////////////////
   // checks
   ////////////////////

   task automatic check_val(input string name, input string what,
                            input logic [7:0] exp, input logic [7:0] act);
      assert (exp === act) else begin
         errors++;
         $display("error %s %s expected %h actual %h", name, what, exp, act);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic check_idle(input string name);
      check_val(name, "out_valid", 8'h00, 8'(out_valid));
      check_val(name, "drop", 8'h00, 8'(drop));
      check_val(name, "seq_error", 8'h00, 8'(seq_error));
   endtask

   task automatic check_cycle(input int c);
      for (int i = 0; i < `ROUTER_PORTS; i++) begin
         check_val(out_name[c][i], "out_valid", 8'(exp_valid[c][i]), 8'(out_valid[i]));
         // flit word only meaningful with its strobe
         if (exp_valid[c][i])
            check_val(out_name[c][i], "out_flit", exp_flit[c][i], out_flit[i]);
         check_val(in_name[c][i], "drop", 8'(exp_drop[c][i]), 8'(drop[i]));
         check_val(in_name[c][i], "seq_error", 8'(exp_seq[c][i]), 8'(seq_error[i]));
      end
   endtask

   task automatic drive_cycle(input int c);
      in_valid = '0;
      for (int r = 0; r < row_name.size(); r++) begin
         if (row_cyc[r] == c) begin
            in_valid[row_port[r]] = 1'b1;
            in_flit[row_port[r]]  = row_flit[r];
         end
      end
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      void'($urandom(32'h0c0e8bc1));
      rst_n    = 1'b0;
      in_valid = '0;
      in_flit  = '0;
      build_table();
      clear_expect();
      for (int r = 0; r < row_name.size(); r++) begin
         expect_row(r);
         if (row_cyc[r] > last_cyc)
            last_cyc = row_cyc[r];
      end
      timeout_limit = row_name.size() + 20 + RST_CYCLES;
      // outputs held low while in reset
      repeat (RST_CYCLES) begin
         @(posedge clk);
         #1;
         check_idle("reset");
      end
      rst_n = 1'b1;
      // cycle 0 also covers the first cycle out of reset
      for (int c = 0; c <= last_cyc + 3; c++) begin
         @(posedge clk);
         #1;
         check_cycle(c);
         drive_cycle(c);
      end
      if (errors == 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("test failed");
         $fatal(1);
      end
   end

   // watchdog on total clock edges
   always @(posedge clk) begin
      cycles++;
      if (cycles > timeout_limit) begin
         $display("timeout, the run did not finish within %0d cycles", timeout_limit);
         $display("test failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

//--- source/mesh_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "noc_macros.svh"

module mesh_router
   import noc_flit_pkg::*;
   import noc_port_pkg::*;
#(
   // router position in the mesh
   parameter int unsigned node_x = 0,
   parameter int unsigned node_y = 0
)(
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire port_vec_t                  in_valid,
   input  wire flit_u [`ROUTER_PORTS-1:0]  in_flit,
   output port_vec_t                       out_valid,
   output flit_u [`ROUTER_PORTS-1:0]       out_flit,
   output port_vec_t                       drop,
   output port_vec_t                       seq_error
);

   // position must lie inside the mesh
   if (node_x >= `MESH_X || node_y >= `MESH_Y) begin : g_bad_node
      $error("mesh_router node position outside the mesh");
   end

   ////////////////////
   // internal links
   ////////////////////

   // ingress register stage to route and switch
   wire port_vec_t                      fwd_valid;
   wire flit_u [`ROUTER_PORTS-1:0]      fwd_flit;
   // one-hot requests per input
   wire port_vec_t [`ROUTER_PORTS-1:0]  req;

   ////////////////////
   // ingress
   ////////////////////

   flit_ingress u_ingress (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .fwd_valid (fwd_valid),
      .fwd_flit  (fwd_flit),
      .seq_error (seq_error)
   );

   ////////////////////
   // route per input
   ////////////////////

   for (genvar p = 0; p < `ROUTER_PORTS; p++) begin : g_route
      xy_route_unit #(
         .node_x (node_x),
         .node_y (node_y)
      ) u_route (
         .clk       (clk),
         .rst_n     (rst_n),
         .fwd_valid (fwd_valid[p]),
         .fwd_flit  (fwd_flit[p]),
         .req       (req[p])
      );
   end

   ////////////////////
   // switch
   ////////////////////

   output_switch u_switch (
      .clk       (clk),
      .rst_n     (rst_n),
      .fwd_valid (fwd_valid),
      .fwd_flit  (fwd_flit),
      .req       (req),
      .out_valid (out_valid),
      .out_flit  (out_flit),
      .drop      (drop)
   );

endmodule

`default_nettype wire

//--- source/output_switch.sv
`timescale 1ns/10ps
`default_nettype none

`include "noc_macros.svh"

module output_switch
   import noc_flit_pkg::*;
   import noc_port_pkg::*;
(
   input  wire                                 clk,
   input  wire                                 rst_n,
   input  wire port_vec_t                      fwd_valid,
   input  wire flit_u [`ROUTER_PORTS-1:0]      fwd_flit,
   input  wire port_vec_t [`ROUTER_PORTS-1:0]  req,
   output port_vec_t                           out_valid,
   output flit_u [`ROUTER_PORTS-1:0]           out_flit,
   output port_vec_t                           drop
);

   // packet holding each output
   port_idx_e owner_q [`ROUTER_PORTS];
   port_vec_t busy_q;

   // gnt[o][p] set when output o goes to input p
   port_vec_t [`ROUTER_PORTS-1:0] gnt;
   // same matrix by input as col[p][o]
   port_vec_t [`ROUTER_PORTS-1:0] col;
   port_idx_e                     win_idx [`ROUTER_PORTS];
   port_vec_t                     is_start;
   port_vec_t                     granted;
   port_vec_t                     has_req;

   ////////////////////
   // allocation
   ////////////////////

   always_comb begin
      for (int p = 0; p < `ROUTER_PORTS; p++) begin
         is_start[p] = fwd_flit[p].hdr.kind inside {FLIT_HEAD, FLIT_SINGLE};
         has_req[p]  = fwd_valid[p] & (|req[p]);
      end
   end

   always_comb begin
      gnt = '0;
      for (int o = 0; o < `ROUTER_PORTS; o++) begin
         win_idx[o] = PORT_LOCAL;
         if (busy_q[o]) begin
            // locked so only the owner passes
            if (fwd_valid[owner_q[o]] && req[owner_q[o]][o]) begin
               gnt[o][owner_q[o]] = 1'b1;
               win_idx[o]         = owner_q[o];
            end
         end else begin
            // free output walks down so the lowest requester is left
            for (int p = `ROUTER_PORTS - 1; p >= 0; p--) begin
               if (fwd_valid[p] && req[p][o] && is_start[p]) begin
                  gnt[o]     = port_vec_t'(1) << p;
                  win_idx[o] = port_idx_e'(p);
               end
            end
         end
      end
   end

   // transpose for the per-input view
   always_comb begin
      for (int p = 0; p < `ROUTER_PORTS; p++) begin
         for (int o = 0; o < `ROUTER_PORTS; o++)
            col[p][o] = gnt[o][p];
         granted[p] = |col[p];
      end
   end

   ////////////////////
   // lock state, strobes
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q    <= '0;
         out_valid <= '0;
         drop      <= '0;
         for (int o = 0; o < `ROUTER_PORTS; o++)
            owner_q[o] <= PORT_LOCAL;
      end else begin
         for (int o = 0; o < `ROUTER_PORTS; o++) begin
            out_valid[o] <= |gnt[o];
            if (|gnt[o]) begin
               // head locks, tail frees, single never locks
               if (fwd_flit[win_idx[o]].hdr.kind == FLIT_HEAD) begin
                  busy_q[o]  <= 1'b1;
                  owner_q[o] <= win_idx[o];
               end else if (fwd_flit[win_idx[o]].hdr.kind == FLIT_TAIL) begin
                  busy_q[o] <= 1'b0;
               end
            end
         end
         // lost or blocked flits are not retried
         drop <= has_req & ~granted;
      end
   end

   // output flit registers
   always_ff @(posedge clk) begin
      for (int o = 0; o < `ROUTER_PORTS; o++) begin
         if (|gnt[o])
            out_flit[o] <= fwd_flit[win_idx[o]];
      end
   end

   ////////////////////
   // checks
   ////////////////////

   for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_chk
      // one flit cannot leave on two outputs
      a_one_out : assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(col[i]));
      // lock taken by an earlier head holds until its tail
      a_lock_held : assert property (@(posedge clk) disable iff (!rst_n)
         busy_q[i] |-> (gnt[i] & ~(port_vec_t'(1) << owner_q[i])) == '0);
   end

endmodule

`default_nettype wire

//--- source/xy_route_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "noc_macros.svh"

module xy_route_unit
   import noc_flit_pkg::*;
   import noc_port_pkg::*;
#(
   parameter int unsigned node_x = 0,
   parameter int unsigned node_y = 0
)(
   input  wire        clk,
   input  wire        rst_n,
   input  wire        fwd_valid,
   input  wire flit_u fwd_flit,
   output port_vec_t  req
);

   // one extra bit so the difference keeps its sign
   localparam int diff_w = `COORD_W + 1;

   localparam logic [`COORD_W-1:0] node_xc = `COORD_W'(node_x);
   localparam logic [`COORD_W-1:0] node_yc = `COORD_W'(node_y);

   logic                      is_start;
   logic signed [diff_w-1:0]  xc;
   logic signed [diff_w-1:0]  yc;
   logic signed [diff_w-1:0]  xd;
   logic signed [diff_w-1:0]  yd;
   logic signed [diff_w-1:0]  xdiff;
   logic signed [diff_w-1:0]  ydiff;
   port_idx_e                 route_dir;
   port_idx_e                 route_q;
   port_idx_e                 sel_dir;

   ////////////////////
   // header decode
   ////////////////////

   // only head and single carry coordinates
   assign is_start = fwd_flit.hdr.kind inside {FLIT_HEAD, FLIT_SINGLE};

   // current node
   assign xc = $signed({1'b0, node_xc});
   assign yc = $signed({1'b0, node_yc});
   // destination
   assign xd = $signed({1'b0, fwd_flit.hdr.dest_x});
   assign yd = $signed({1'b0, fwd_flit.hdr.dest_y});

   assign xdiff = xd - xc;
   assign ydiff = yd - yc;

   ////////////////////
   // dimension order
   ////////////////////

   // x first, then y, local when both match
   always_comb begin
      route_dir = PORT_LOCAL;
      if (xdiff > 0)
         route_dir = PORT_EAST;
      else if (xdiff < 0)
         route_dir = PORT_WEST;
      else if (ydiff > 0)
         route_dir = PORT_SOUTH;
      else if (ydiff < 0)
         route_dir = PORT_NORTH;
   end

   // packet route, held for body and tail
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         route_q <= PORT_LOCAL;
      else if (fwd_valid && is_start)
         route_q <= route_dir;
   end

   // head uses the fresh route in its own cycle
   assign sel_dir = is_start ? route_dir : route_q;

   ////////////////////
   // request
   ////////////////////

   // one-hot toward the chosen output, idle when no flit
   assign req = fwd_valid ? (port_vec_t'(1) << sel_dir) : '0;

   // switch relies on exactly one request per flit
   a_req_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      fwd_valid |-> $onehot(req));

endmodule

`default_nettype wire

//--- source/flit_ingress.sv
`timescale 1ns/10ps
`default_nettype none

`include "noc_macros.svh"

module flit_ingress
   import noc_flit_pkg::*;
   import noc_port_pkg::*;
(
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire port_vec_t                  in_valid,
   input  wire flit_u [`ROUTER_PORTS-1:0]  in_flit,
   output port_vec_t                       fwd_valid,
   output flit_u [`ROUTER_PORTS-1:0]       fwd_flit,
   output port_vec_t                       seq_error
);

   // one bit per port, set between head and tail
   port_vec_t open_q;
   // flit kind fits the packet state
   port_vec_t in_order;
   port_vec_t accept;

   ////////////////////
   // order check
   ////////////////////

   always_comb begin
      for (int p = 0; p < `ROUTER_PORTS; p++) begin
         // head and single only outside a packet
         if (in_flit[p].dat.kind inside {FLIT_HEAD, FLIT_SINGLE})
            in_order[p] = ~open_q[p];
         // body and tail only inside one
         else
            in_order[p] = open_q[p];
      end
   end

   assign accept = in_valid & in_order;

   ////////////////////
   // register stage
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fwd_valid <= '0;
         seq_error <= '0;
         open_q    <= '0;
      end else begin
         fwd_valid <= accept;
         // one-cycle flag, flit is dropped
         seq_error <= in_valid & ~in_order;
         for (int p = 0; p < `ROUTER_PORTS; p++) begin
            if (accept[p]) begin
               // head opens, tail closes, body and single leave it
               if (in_flit[p].dat.kind == FLIT_HEAD)
                  open_q[p] <= 1'b1;
               else if (in_flit[p].dat.kind == FLIT_TAIL)
                  open_q[p] <= 1'b0;
            end
         end
      end
   end

   // flit word only moves with an accepted strobe
   always_ff @(posedge clk) begin
      for (int p = 0; p < `ROUTER_PORTS; p++) begin
         if (accept[p])
            fwd_flit[p] <= in_flit[p];
      end
   end

   // a rejected flit must not reach the route units
   a_err_not_fwd : assert property (@(posedge clk) disable iff (!rst_n)
      (seq_error & fwd_valid) == '0);

endmodule

`default_nettype wire

//--- source/noc_port_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_port_pkg;

   ////////////////////
   // port numbering
   ////////////////////

   // L, E, N, W, S counted from zero
   typedef enum logic [2:0] {
      PORT_LOCAL = 3'd0,
      PORT_EAST  = 3'd1,
      PORT_NORTH = 3'd2,
      PORT_WEST  = 3'd3,
      PORT_SOUTH = 3'd4
   } port_idx_e;

   ////////////////////
   // port vectors
   ////////////////////

   // one bit per port, indexed by port_idx_e
   // route requests, strobes and pulses
   typedef logic [`ROUTER_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire

//--- source/noc_flit_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_flit_pkg;

   ////////////////////
   // flit kind
   ////////////////////

   // head 10, body 00, tail 01 as on the older routers
   // single is a one-flit packet
   typedef enum logic [1:0] {
      FLIT_BODY   = 2'b00,
      FLIT_TAIL   = 2'b01,
      FLIT_HEAD   = 2'b10,
      FLIT_SINGLE = 2'b11
   } flit_kind_e;

   ////////////////////
   // flit views
   ////////////////////

   // head and single flits carry the destination
   typedef struct packed {
      flit_kind_e                               kind;
      logic [`FLIT_W-3-2*`COORD_W:0]            spare;
      logic [`COORD_W-1:0]                      dest_y;
      logic [`COORD_W-1:0]                      dest_x;
   } flit_hdr_t;

   // body and tail flits carry payload
   typedef struct packed {
      flit_kind_e        kind;
      logic [`FLIT_W-3:0] data;
   } flit_dat_t;

   // one word, decoded by kind
   typedef union packed {
      flit_hdr_t hdr;
      flit_dat_t dat;
   } flit_u;

endpackage

`default_nettype wire

//--- include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

////////////////////
// router geometry
////////////////////

// local, east, north, west, south
`define ROUTER_PORTS 5

// flit word, kind in the top two bits
`define FLIT_W 8

// one mesh coordinate
`define COORD_W 2

// mesh size, bounds the node position
`define MESH_X 4
`define MESH_Y 4

`endif
